// ==== design/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

  // apb byte address, enough for four word registers.
  typedef logic [3:0] apb_addr_t;

  // apb data word.
  typedef logic [31:0] apb_data_t;

  // scale shift amount, 0 to 3 bit positions.
  typedef logic [1:0] shift_t;

  // register map.
  localparam apb_addr_t ADDR_OPERANDS = 4'h0;
  localparam apb_addr_t ADDR_CTRL     = 4'h4;
  localparam apb_addr_t ADDR_ACC      = 4'h8;
  localparam apb_addr_t ADDR_RESULT   = 4'hC;

endpackage

`default_nettype wire

// ==== design/mac_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mac_if
  import mac_pkg::*;
#(
  parameter int OP_W  = 8,
  parameter int ACC_W = 16
);

  // operands and command pulses from the register block.
  logic [OP_W-1:0]  op_a;
  logic [OP_W-1:0]  op_b;
  logic             step;
  logic             clear;
  shift_t           shift;

  // status and results from the datapath.
  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] quotient;
  logic [2:0]       remainder;
  logic             overflow;

  modport regs (
    output op_a, op_b, step, clear, shift,
    input  acc, quotient, remainder, overflow
  );

  modport datapath (
    input  op_a, op_b, step, clear, shift,
    output acc, quotient, remainder, overflow
  );

endinterface

`default_nettype wire

// ==== design/cla_adder.sv ====
`timescale 1ns/1ns
`default_nettype none

module cla_adder #(
  parameter int WIDTH = 16
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic [WIDTH-1:0] sum,
  output logic             cout
);

  localparam int NG = WIDTH / 4;

  logic [WIDTH-1:0] p;
  logic [WIDTH-1:0] g;
  logic [NG-1:0]    grp_p;
  logic [NG-1:0]    grp_g;
  logic [NG:0]      grp_c;

  assign p = a ^ b;
  assign g = a & b;

  // each group resolves its own carries from the group carry in.
  genvar k;
  generate
    for (k = 0; k < NG; k++)
    begin : g_group
      logic [3:0] gp;
      logic [3:0] gg;
      logic [3:0] c;

      assign gp = p[4*k +: 4];
      assign gg = g[4*k +: 4];

      assign c[0] = grp_c[k];
      assign c[1] = gg[0] | (gp[0] & grp_c[k]);
      assign c[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & grp_c[k]);
      assign c[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0]) |
                    (gp[2] & gp[1] & gp[0] & grp_c[k]);

      assign sum[4*k +: 4] = gp ^ c;

      assign grp_p[k] = &gp;
      assign grp_g[k] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1]) |
                        (gp[3] & gp[2] & gp[1] & gg[0]);
    end
  endgenerate

  // second lookahead level, expanded to a flat sum of products per group.
  always_comb
  begin
    logic term;
    logic carry;
    grp_c[0] = cin;
    for (int k2 = 1; k2 <= NG; k2++)
    begin
      term = cin;
      for (int m = 0; m < k2; m++)
        term = term & grp_p[m];
      carry = term;
      for (int j = 0; j < k2; j++)
      begin
        term = grp_g[j];
        for (int m = j + 1; m < k2; m++)
          term = term & grp_p[m];
        carry = carry | term;
      end
      grp_c[k2] = carry;
    end
  end

  assign cout = grp_c[NG];

endmodule

`default_nettype wire

// ==== design/array_multiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

module array_multiplier #(
  parameter int OP_W = 8
) (
  input  logic [OP_W-1:0]   a,
  input  logic [OP_W-1:0]   b,
  output logic [2*OP_W-1:0] product
);

  localparam int PW = 2 * OP_W;

  logic [PW-1:0] a_ext;
  logic [PW-1:0] pp [OP_W];
  logic [PW-1:0] partial_sum [OP_W+1];

  assign a_ext = PW'(a);
  assign partial_sum[0] = '0;

  // row i is a shifted left by i, kept only when b[i] is set.
  genvar i;
  generate
    for (i = 0; i < OP_W; i++)
    begin : g_row
      assign pp[i] = (a_ext << i) & {PW{b[i]}};
      assign partial_sum[i+1] = partial_sum[i] + pp[i];
    end
  endgenerate

  assign product = partial_sum[OP_W];

endmodule

`default_nettype wire

// ==== design/mac_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_datapath #(
  parameter int OP_W  = 8,
  parameter int ACC_W = 16
) (
  input  logic   C,
  input  logic   CLR,
  mac_if.datapath bus
);

  logic [2*OP_W-1:0] product;
  logic [ACC_W-1:0]  addend;
  logic [ACC_W-1:0]  sum;
  logic              carry_out;
  logic [ACC_W-1:0]  acc_q;
  logic              overflow_q;
  logic [2:0]        rem;

  array_multiplier #(
    .OP_W (OP_W)
  ) mult_i (
    .a       (bus.op_a),
    .b       (bus.op_b),
    .product (product)
  );

  // the product is unsigned, so it widens with zeros.
  assign addend = ACC_W'(product);

  cla_adder #(
    .WIDTH (ACC_W)
  ) add_i (
    .a    (acc_q),
    .b    (addend),
    .cin  (1'b0),
    .sum  (sum),
    .cout (carry_out)
  );

  // accumulator; a clear pulse takes priority over a step.
  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
      acc_q <= '0;
    else if (bus.clear)
      acc_q <= '0;
    else if (bus.step)
      acc_q <= sum;
  end

  // overflow stays set until the accumulator is cleared.
  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
      overflow_q <= 1'b0;
    else if (bus.clear)
      overflow_q <= 1'b0;
    else if (bus.step && carry_out)
      overflow_q <= 1'b1;
  end

  // the bits shifted out form the remainder.
  always_comb
  begin
    case (bus.shift)
      2'd0:    rem = 3'b000;
      2'd1:    rem = {2'b00, acc_q[0]};
      2'd2:    rem = {1'b0, acc_q[1:0]};
      default: rem = acc_q[2:0];
    endcase
  end

  assign bus.acc       = acc_q;
  assign bus.overflow  = overflow_q;
  assign bus.quotient  = acc_q >> bus.shift;
  assign bus.remainder = rem;

endmodule

`default_nettype wire

// ==== design/apb_mac_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_mac_regs
  import mac_pkg::*;
#(
  parameter int OP_W  = 8,
  parameter int ACC_W = 16
) (
  input  logic      C,
  input  logic      CLR,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pslverr,
  mac_if.regs       bus
);

  logic            access;
  logic            wr;
  logic            rd;
  logic            hit_operands;
  logic            hit_ctrl;
  logic            hit_acc;
  logic            hit_result;
  logic            mapped;
  logic            wr_operands;
  logic            wr_ctrl;
  logic [OP_W-1:0] op_a_q;
  logic [OP_W-1:0] op_b_q;
  shift_t          shift_q;
  apb_data_t       rdata;

  // with pready tied high every access phase completes at the next edge.
  assign access = psel & penable;
  assign wr     = access & pwrite;
  assign rd     = access & ~pwrite;

  assign hit_operands = (paddr == ADDR_OPERANDS);
  assign hit_ctrl     = (paddr == ADDR_CTRL);
  assign hit_acc      = (paddr == ADDR_ACC);
  assign hit_result   = (paddr == ADDR_RESULT);
  assign mapped       = hit_operands | hit_ctrl | hit_acc | hit_result;

  assign wr_operands = wr & hit_operands;
  assign wr_ctrl     = wr & hit_ctrl;

  // ACC and RESULT are read only, so a write to either is an error.
  assign pslverr = access & (~mapped | (pwrite & (hit_acc | hit_result)));

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      op_a_q <= '0;
      op_b_q <= '0;
    end
    else if (wr_operands)
    begin
      op_a_q <= pwdata[OP_W-1:0];
      op_b_q <= pwdata[OP_W+7:8];
    end
  end

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
      shift_q <= '0;
    else if (wr_ctrl)
      shift_q <= pwdata[2:1];
  end

  // the operands being written go straight to the multiplier, so the step
  // in this cycle uses them and not the previous values.
  assign bus.op_a  = wr_operands ? pwdata[OP_W-1:0] : op_a_q;
  assign bus.op_b  = wr_operands ? pwdata[OP_W+7:8] : op_b_q;
  assign bus.step  = wr_operands;
  assign bus.clear = wr_ctrl & pwdata[0];
  assign bus.shift = shift_q;

  // read multiplexer.
  always_comb
  begin
    rdata = '0;
    case (paddr)
      ADDR_OPERANDS:
      begin
        rdata[OP_W-1:0]  = op_a_q;
        rdata[OP_W+7:8]  = op_b_q;
      end
      ADDR_CTRL:
      begin
        rdata[2:1] = shift_q;
      end
      ADDR_ACC:
      begin
        rdata[ACC_W-1:0] = bus.acc;
      end
      ADDR_RESULT:
      begin
        rdata[ACC_W-1:0] = bus.quotient;
        rdata[30:28]     = bus.remainder;
        rdata[31]        = bus.overflow;
      end
      default:
      begin
        rdata = '0;
      end
    endcase
  end

  // read data is only presented in the access phase of a read.
  assign prdata = rd ? rdata : '0;

endmodule

`default_nettype wire

// ==== design/mac_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_top
  import mac_pkg::*;
#(
  parameter int OP_W  = 8,
  parameter int ACC_W = 16
) (
  input  logic      C,
  input  logic      CLR,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  mac_if #(
    .OP_W  (OP_W),
    .ACC_W (ACC_W)
  ) mac_bus ();

  apb_mac_regs #(
    .OP_W  (OP_W),
    .ACC_W (ACC_W)
  ) regs_i (
    .C       (C),
    .CLR     (CLR),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .bus     (mac_bus.regs)
  );

  mac_datapath #(
    .OP_W  (OP_W),
    .ACC_W (ACC_W)
  ) datapath_i (
    .C   (C),
    .CLR (CLR),
    .bus (mac_bus.datapath)
  );

  // the slave never inserts wait states.
  assign pready = 1'b1;

endmodule

`default_nettype wire

// ==== bench/mac_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_assert #(
  parameter int ACC_W = 16
) (
  input logic             C,
  input logic             CLR,
  input logic             psel,
  input logic             penable,
  input logic             pready,
  input logic             pslverr,
  input logic             step,
  input logic             clear,
  input logic [ACC_W-1:0] acc
);

  // counts assertion failures so the testbench can see them at the end.
  int failures = 0;

  a_pready_high: assert property (@(posedge C) disable iff (CLR) pready)
    else begin failures++; $error("pready low outside reset"); end

  a_err_in_access: assert property (@(posedge C) disable iff (CLR)
                                    pslverr |-> (psel && penable))
    else begin failures++; $error("pslverr high outside an access phase"); end

  a_clear_zeroes: assert property (@(posedge C) disable iff (CLR) clear |=> (acc == '0))
    else begin failures++; $error("acc not zero after clear"); end

  a_acc_holds: assert property (@(posedge C) disable iff (CLR)
                                (!step && !clear) |=> $stable(acc))
    else begin failures++; $error("acc changed without step or clear"); end

endmodule

bind mac_top mac_assert #(
  .ACC_W (ACC_W)
) assert_i (
  .C       (C),
  .CLR     (CLR),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .step    (mac_bus.step),
  .clear   (mac_bus.clear),
  .acc     (mac_bus.acc)
);

`default_nettype wire

// ==== bench/mac_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_tb
  import mac_pkg::*;
;

  localparam int OP_W         = 8;
  localparam int ACC_W        = 16;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int N_RANDOM     = 20;

  // the transfer count adds the reset reads, the random steps with their reads,
  // the overflow sequence, the shift sweep, operand read-back and the error responses.
  localparam int N_XFERS = 3 + 2 * N_RANDOM + 10 + 16 + 2 + 4;
  localparam int WATCHDOG_CYCLES = N_XFERS * 2 * 2 + RESET_CYCLES;

  logic      C;
  logic      CLR;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  // expectations for the transfer currently on the bus.
  apb_data_t exp_rdata;
  logic      exp_err;

  // reference model state.
  logic [ACC_W-1:0] m_acc;
  logic             m_ovf;
  shift_t           m_shift;
  logic [OP_W-1:0]  m_op_a;
  logic [OP_W-1:0]  m_op_b;
  logic [15:0]      lfsr_state;

  mac_top #(
    .OP_W  (OP_W),
    .ACC_W (ACC_W)
  ) dut_i (
    .C       (C),
    .CLR     (CLR),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(CLK_PERIOD / 2) C = ~C;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // galois form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    else
      return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // one multiply-accumulate step that returns the sticky overflow above the sum.
  function automatic logic [ACC_W:0] mac_model(input logic ovf, input logic [ACC_W-1:0] acc,
                                               input logic [OP_W-1:0] a,
                                               input logic [OP_W-1:0] b);
    logic [31:0] total;
    total = 32'(acc) + 32'(a) * 32'(b);
    return {ovf | (total > 32'((2 ** ACC_W) - 1)), total[ACC_W-1:0]};
  endfunction

  task automatic model_write(input apb_addr_t addr, input apb_data_t data);
    logic [ACC_W:0] next;
    case (addr)
      ADDR_OPERANDS:
      begin
        m_op_a = data[OP_W-1:0];
        m_op_b = data[OP_W+7:8];
        next = mac_model(m_ovf, m_acc, m_op_a, m_op_b);
        m_ovf = next[ACC_W];
        m_acc = next[ACC_W-1:0];
      end
      ADDR_CTRL:
      begin
        m_shift = data[2:1];
        if (data[0])
        begin
          m_acc = '0;
          m_ovf = 1'b0;
        end
      end
      default:
      begin
      end
    endcase
  endtask

  // the scaler is a division by a power of two.
  function automatic apb_data_t expected_read(input apb_addr_t addr);
    apb_data_t   d;
    int unsigned div;
    d = '0;
    div = 1 << m_shift;
    case (addr)
      ADDR_OPERANDS:
      begin
        d[OP_W-1:0] = m_op_a;
        d[OP_W+7:8] = m_op_b;
      end
      ADDR_CTRL:
        d[2:1] = m_shift;
      ADDR_ACC:
        d[ACC_W-1:0] = m_acc;
      ADDR_RESULT:
      begin
        d[ACC_W-1:0] = ACC_W'(m_acc / div);
        d[30:28]     = 3'(m_acc % div);
        d[31]        = m_ovf;
      end
      default:
        d = '0;
    endcase
    return d;
  endfunction

  function automatic logic expected_error(input apb_addr_t addr, input logic write);
    case (addr)
      ADDR_OPERANDS, ADDR_CTRL:
        return 1'b0;
      ADDR_ACC, ADDR_RESULT:
        return write;
      default:
        return 1'b1;
    endcase
  endfunction

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge C);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    exp_err <= expected_error(addr, 1'b1);
    @(posedge C);
    penable <= 1'b1;
    model_write(addr, data);
  endtask

  task automatic apb_read(input apb_addr_t addr);
    @(posedge C);
    psel      <= 1'b1;
    penable   <= 1'b0;
    pwrite    <= 1'b0;
    paddr     <= addr;
    pwdata    <= '0;
    exp_err   <= expected_error(addr, 1'b0);
    exp_rdata <= expected_read(addr);
    @(posedge C);
    penable <= 1'b1;
  endtask

  task automatic apb_idle();
    @(posedge C);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // every access phase is checked in the middle of the cycle.
  always @(negedge C)
  begin
    if (!CLR && psel && penable)
    begin
      check_value("pready", 32'(1'b1), 32'(pready));
      check_value("pslverr", 32'(exp_err), 32'(pslverr));
      if (!pwrite && !exp_err)
        check_value("prdata", exp_rdata, prdata);
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the APB sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    logic [31:0] r;
    C = 1'b0;
    CLR = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    exp_rdata = '0;
    exp_err = 1'b0;
    m_acc = '0;
    m_ovf = 1'b0;
    m_shift = '0;
    m_op_a = '0;
    m_op_b = '0;
    lfsr_state = 16'd4;
    repeat (RESET_CYCLES) @(posedge C);
    CLR <= 1'b0;

    apb_read(ADDR_ACC);
    apb_read(ADDR_RESULT);
    apb_read(ADDR_CTRL);

    // enough random products to wrap the accumulator.
    for (int i = 0; i < N_RANDOM; i++)
    begin
      take_bits(16, r);
      apb_write(ADDR_OPERANDS, {16'h0, r[15:0]});
      apb_read(ADDR_ACC);
    end

    // 255 * 255 twice carries out of 16 bits, and overflow must stick.
    apb_write(ADDR_CTRL, 32'h1);
    apb_write(ADDR_OPERANDS, 32'h0000_FFFF);
    apb_read(ADDR_RESULT);
    apb_write(ADDR_OPERANDS, 32'h0000_FFFF);
    apb_read(ADDR_RESULT);
    apb_write(ADDR_OPERANDS, 32'h0000_0102);
    apb_read(ADDR_RESULT);
    apb_write(ADDR_CTRL, 32'h1);
    apb_read(ADDR_ACC);
    apb_read(ADDR_RESULT);

    for (int s = 0; s < 4; s++)
    begin
      apb_write(ADDR_CTRL, apb_data_t'((s << 1) | 1));
      take_bits(16, r);
      apb_write(ADDR_OPERANDS, {16'h0, r[15:0]});
      apb_read(ADDR_CTRL);
      apb_read(ADDR_RESULT);
    end

    take_bits(16, r);
    apb_write(ADDR_OPERANDS, {16'h0, r[15:0]});
    apb_read(ADDR_OPERANDS);

    apb_read(4'hD);
    apb_write(ADDR_ACC, 32'hFFFF_FFFF);
    apb_write(ADDR_RESULT, 32'h1234_5678);
    apb_read(ADDR_ACC);
    apb_idle();
    repeat (2) @(posedge C);

    if (dut_i.assert_i.failures == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/mac_pkg.sv
design/mac_if.sv
design/cla_adder.sv
design/array_multiplier.sv
design/mac_datapath.sv
design/apb_mac_regs.sv
design/mac_top.sv
bench/mac_assert.sv
bench/mac_tb.sv

// ==== Bender.yml ====
package:
  name: apb_mac

sources:
  - files:
      - design/mac_pkg.sv
      - design/mac_if.sv
      - design/cla_adder.sv
      - design/array_multiplier.sv
      - design/mac_datapath.sv
      - design/apb_mac_regs.sv
      - design/mac_top.sv
  - target: test
    files:
      - bench/mac_assert.sv
      - bench/mac_tb.sv
